// ==== logic/xcvr_bus_pkg.sv ====
// Bus widths and request/response structs for the shared host port and the
// per-channel reconfiguration ports
package xcvr_bus_pkg;

  // Per-channel reconfiguration address width
  localparam int ADDR_BITS    = 10;
  localparam int HOST_DATA_W  = 32;
  localparam int CHAN_DATA_W  = 8;

  // Address bit that steers an access to the soft CSR instead of the PHY
  localparam int CSR_SEL_BIT  = 9;

  // Fixed channel-select field above ADDR_BITS in the host address
  localparam int MAX_SEL_BITS = 4;
  localparam int HOST_ADDR_W  = ADDR_BITS + MAX_SEL_BITS;

  typedef struct packed {
    logic                   write;
    logic                   read;
    logic [HOST_ADDR_W-1:0] address;
    logic [HOST_DATA_W-1:0] writedata;
  } host_req_t;

  typedef struct packed {
    logic [HOST_DATA_W-1:0] readdata;
    logic                   waitrequest;
  } host_rsp_t;

  typedef struct packed {
    logic                   write;
    logic                   read;
    logic [ADDR_BITS-1:0]   address;
    logic [CHAN_DATA_W-1:0] writedata;
  } chan_req_t;

  typedef struct packed {
    logic [CHAN_DATA_W-1:0] readdata;
    logic                   waitrequest;
  } chan_rsp_t;

endpackage

// ==== logic/xcvr_dbg_pkg.sv ====
// Register map and PHY control/status types of the per-channel debug CSR,
// shared by the CSR, the PRBS accumulator and the top level
package xcvr_dbg_pkg;

  // Live and snapshot PRBS counter width
  localparam int PRBS_CNT_W = 50;
  // Bytes needed to read one counter over the 8-bit port
  localparam int PRBS_BYTES = 7;

  // Offsets inside the soft CSR window, bit 9 already stripped
  typedef enum logic [8:0] {
    REG_ID        = 9'h000,
    REG_STATUS    = 9'h001,
    REG_OVR_EN    = 9'h010,
    REG_OVR_VAL   = 9'h011,
    REG_CAL_MASK  = 9'h012,
    REG_PRBS_CTRL = 9'h020,
    // First of 7 error count bytes, 0x021 to 0x027
    REG_PRBS_ERR0 = 9'h021,
    // First of 7 bit count bytes, 0x028 to 0x02E
    REG_PRBS_BIT0 = 9'h028
  } csr_reg_e;

  // Declared MSB first, so set_rx_locktoref lands on bit 0
  typedef struct packed {
    logic tx_digitalreset;
    logic tx_analogreset;
    logic rx_digitalreset;
    logic rx_analogreset;
    logic en_serial_lpbk;
    logic set_rx_locktodata;
    logic set_rx_locktoref;
  } phy_ctrl_t;

  // rx_is_lockedtoref on bit 0
  typedef struct packed {
    logic avmm_busy;
    logic rx_cal_busy;
    logic tx_cal_busy;
    logic rx_is_lockedtodata;
    logic rx_is_lockedtoref;
  } phy_status_t;

  // Same bit order as REG_PRBS_CTRL
  typedef struct packed {
    logic clear;
    logic snap;
    logic count_en;
  } prbs_ctrl_t;

endpackage

// ==== logic/rcfg_channel_split.sv ====
// Splits the shared host bus into per-channel reconfiguration buses using the
// address bits above the channel window
module rcfg_channel_split #(
  parameter int CHANNELS = 4
) (
  input  xcvr_bus_pkg::host_req_t host_req,
  output xcvr_bus_pkg::host_rsp_t host_rsp,
  output xcvr_bus_pkg::chan_req_t chan_req [CHANNELS],
  input  xcvr_bus_pkg::chan_rsp_t chan_rsp [CHANNELS]
);
  import xcvr_bus_pkg::*;

  // At least one select bit, even for a single channel
  localparam int SEL_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  logic [MAX_SEL_BITS-1:0] sel_field;
  logic [SEL_W-1:0]        chan_sel;
  logic                    in_range;

  // Whole upper field is checked so that unused selects are caught
  assign sel_field = host_req.address[ADDR_BITS +: MAX_SEL_BITS];
  assign chan_sel  = sel_field[SEL_W-1:0];
  assign in_range  = (sel_field < CHANNELS);

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
    logic hit;

    assign hit = in_range && (sel_field == MAX_SEL_BITS'(ch));

    // Strobes only to the addressed channel, address and data to all
    assign chan_req[ch].write     = host_req.write & hit;
    assign chan_req[ch].read      = host_req.read & hit;
    assign chan_req[ch].address   = host_req.address[ADDR_BITS-1:0];
    assign chan_req[ch].writedata = host_req.writedata[CHAN_DATA_W-1:0];
  end

  always_comb begin
    // Out-of-range selects complete at once with zero data
    host_rsp.readdata    = '0;
    host_rsp.waitrequest = 1'b0;
    if (in_range) begin
      host_rsp.readdata    = {{(HOST_DATA_W-CHAN_DATA_W){1'b0}},
                              chan_rsp[chan_sel].readdata};
      host_rsp.waitrequest = chan_rsp[chan_sel].waitrequest;
    end
  end

endmodule

// ==== logic/dbg_soft_csr.sv ====
// Per-channel debug register file; address bit 9 picks this CSR or the PHY
// reconfiguration port, and the CSR can override the PHY control lines
module dbg_soft_csr #(
  parameter logic [7:0] DBG_USER_ID = 8'h00
) (
  input  logic                                reconfig_clk,
  input  logic                                reset,
  input  xcvr_bus_pkg::chan_req_t             bus_req,
  output xcvr_bus_pkg::chan_rsp_t             bus_rsp,
  output xcvr_bus_pkg::chan_req_t             phy_req,
  input  xcvr_bus_pkg::chan_rsp_t             phy_rsp,
  input  xcvr_dbg_pkg::phy_status_t           phy_status,
  input  xcvr_dbg_pkg::phy_ctrl_t             ctrl_in,
  output xcvr_dbg_pkg::phy_ctrl_t             ctrl_out,
  output logic                                tx_cal_busy_mask,
  output logic                                rx_cal_busy_mask,
  output xcvr_dbg_pkg::prbs_ctrl_t            prbs_ctrl,
  input  logic                                prbs_done,
  input  logic [xcvr_dbg_pkg::PRBS_CNT_W-1:0] err_snap,
  input  logic [xcvr_dbg_pkg::PRBS_CNT_W-1:0] bit_snap
);
  import xcvr_bus_pkg::*;
  import xcvr_dbg_pkg::*;

  logic                             csr_sel;
  logic                             csr_ack;
  logic                             csr_wr;
  logic [CSR_SEL_BIT-1:0]           offset;
  logic [CHAN_DATA_W-1:0]           csr_rdata;
  phy_ctrl_t                        ovr_en;
  phy_ctrl_t                        ovr_val;
  logic [1:0]                       cal_mask;
  logic [PRBS_BYTES-1:0][7:0]       err_bytes;
  logic [PRBS_BYTES-1:0][7:0]       bit_bytes;
  logic [2:0]                       err_idx;
  logic [2:0]                       bit_idx;
  logic                             err_hit;
  logic                             bit_hit;

  assign csr_sel = bus_req.address[CSR_SEL_BIT];
  assign offset  = bus_req.address[CSR_SEL_BIT-1:0];

  // PHY sees the request only when bit 9 is clear
  always_comb begin
    phy_req       = bus_req;
    phy_req.write = bus_req.write & ~csr_sel;
    phy_req.read  = bus_req.read & ~csr_sel;
  end

  // CSR access holds waitrequest for one cycle, then completes
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      csr_ack <= 1'b0;
    end else begin
      csr_ack <= csr_sel & (bus_req.read | bus_req.write) & ~csr_ack;
    end
  end

  assign csr_wr = csr_sel & bus_req.write & csr_ack;

  always_comb begin
    if (csr_sel) begin
      bus_rsp.readdata    = csr_rdata;
      bus_rsp.waitrequest = ~csr_ack;
    end else begin
      bus_rsp = phy_rsp;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      ovr_en    <= '0;
      ovr_val   <= '0;
      cal_mask  <= 2'b11;
      prbs_ctrl <= '0;
    end else begin
      // Snap and clear are single-cycle strobes
      prbs_ctrl.snap  <= 1'b0;
      prbs_ctrl.clear <= 1'b0;
      if (csr_wr) begin
        case (offset)
          REG_OVR_EN:   ovr_en   <= bus_req.writedata[$bits(phy_ctrl_t)-1:0];
          REG_OVR_VAL:  ovr_val  <= bus_req.writedata[$bits(phy_ctrl_t)-1:0];
          REG_CAL_MASK: cal_mask <= bus_req.writedata[1:0];
          REG_PRBS_CTRL: begin
            prbs_ctrl.count_en <= bus_req.writedata[0];
            prbs_ctrl.snap     <= bus_req.writedata[1];
            prbs_ctrl.clear    <= bus_req.writedata[2];
          end
          default: ;
        endcase
      end
    end
  end

  // Per-bit override of the PHY control lines
  assign ctrl_out         = (ovr_en & ovr_val) | (~ovr_en & ctrl_in);
  assign tx_cal_busy_mask = cal_mask[0];
  assign rx_cal_busy_mask = cal_mask[1];

  // Snapshot counters as byte arrays, LS byte first
  assign err_bytes = (PRBS_BYTES*8)'(err_snap);
  assign bit_bytes = (PRBS_BYTES*8)'(bit_snap);
  assign err_idx   = 3'(offset - REG_PRBS_ERR0);
  assign bit_idx   = 3'(offset - REG_PRBS_BIT0);
  assign err_hit   = (offset >= REG_PRBS_ERR0) && (offset < REG_PRBS_BIT0);
  assign bit_hit   = (offset >= REG_PRBS_BIT0) && (offset < REG_PRBS_BIT0 + PRBS_BYTES);

  always_comb begin
    csr_rdata = '0;
    case (offset)
      REG_ID:        csr_rdata = DBG_USER_ID;
      REG_STATUS:    csr_rdata = {3'b000, phy_status};
      REG_OVR_EN:    csr_rdata = {1'b0, ovr_en};
      REG_OVR_VAL:   csr_rdata = {1'b0, ovr_val};
      REG_CAL_MASK:  csr_rdata = {6'b000000, cal_mask};
      REG_PRBS_CTRL: csr_rdata = {4'b0000, prbs_done, 2'b00, prbs_ctrl.count_en};
      default: begin
        if (err_hit) begin
          csr_rdata = err_bytes[err_idx];
        end else if (bit_hit) begin
          csr_rdata = bit_bytes[bit_idx];
        end
      end
    endcase
  end

endmodule

// ==== logic/prbs_accum.sv ====
// PRBS error and bit accumulator for one channel, with snapshot registers
// read back through the debug CSR
module prbs_accum (
  input  logic                                reconfig_clk,
  input  logic                                reset,
  input  xcvr_dbg_pkg::prbs_ctrl_t            prbs_ctrl,
  input  logic                                rx_prbs_err_clr,
  input  logic                                prbs_err_signal,
  input  logic                                prbs_done_signal,
  output logic                                prbs_err_clr,
  output logic                                prbs_done,
  output logic [xcvr_dbg_pkg::PRBS_CNT_W-1:0] err_snap,
  output logic [xcvr_dbg_pkg::PRBS_CNT_W-1:0] bit_snap
);
  import xcvr_dbg_pkg::*;

  logic [PRBS_CNT_W-1:0] err_cnt;
  logic [PRBS_CNT_W-1:0] bit_cnt;

  // Clear from the CSR or from the PHY side, also sent out to the PHY checker
  assign prbs_err_clr = prbs_ctrl.clear | rx_prbs_err_clr;

  always_ff @(posedge reconfig_clk) begin
    if (reset || prbs_err_clr) begin
      err_cnt  <= '0;
      bit_cnt  <= '0;
      err_snap <= '0;
      bit_snap <= '0;
    end else begin
      if (prbs_ctrl.count_en) begin
        bit_cnt <= bit_cnt + PRBS_CNT_W'(1);
        if (prbs_err_signal) begin
          err_cnt <= err_cnt + PRBS_CNT_W'(1);
        end
      end
      // Copy takes the counters as they stand before this edge
      if (prbs_ctrl.snap) begin
        err_snap <= err_cnt;
        bit_snap <= bit_cnt;
      end
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      prbs_done <= 1'b0;
    end else begin
      prbs_done <= prbs_done_signal;
    end
  end

endmodule

// ==== logic/xcvr_rcfg_top.sv ====
// Reconfiguration front end: host bus split per channel, each channel with
// its debug CSR in front of the PHY port and a PRBS accumulator
module xcvr_rcfg_top #(
  parameter int         CHANNELS    = 4,
  parameter logic [7:0] DBG_USER_ID = 8'h00
) (
  input  logic                        reconfig_clk,
  input  logic                        reset,
  input  xcvr_bus_pkg::host_req_t     host_req,
  output xcvr_bus_pkg::host_rsp_t     host_rsp,
  output xcvr_bus_pkg::chan_req_t     phy_req [CHANNELS],
  input  xcvr_bus_pkg::chan_rsp_t     phy_rsp [CHANNELS],
  input  xcvr_dbg_pkg::phy_status_t   phy_status [CHANNELS],
  input  xcvr_dbg_pkg::phy_ctrl_t     ctrl_in [CHANNELS],
  output xcvr_dbg_pkg::phy_ctrl_t     ctrl_out [CHANNELS],
  output logic [CHANNELS-1:0]         tx_cal_busy_mask,
  output logic [CHANNELS-1:0]         rx_cal_busy_mask,
  input  logic [CHANNELS-1:0]         prbs_err_signal,
  input  logic [CHANNELS-1:0]         prbs_done_signal,
  input  logic [CHANNELS-1:0]         rx_prbs_err_clr,
  output logic [CHANNELS-1:0]         prbs_err_clr
);
  import xcvr_bus_pkg::*;
  import xcvr_dbg_pkg::*;

  chan_req_t split_req [CHANNELS];
  chan_rsp_t split_rsp [CHANNELS];

  rcfg_channel_split #(
    .CHANNELS (CHANNELS)
  ) u_split (
    .host_req (host_req),
    .host_rsp (host_rsp),
    .chan_req (split_req),
    .chan_rsp (split_rsp)
  );

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
    prbs_ctrl_t            prbs_ctrl;
    logic                  prbs_done;
    logic [PRBS_CNT_W-1:0] err_snap;
    logic [PRBS_CNT_W-1:0] bit_snap;

    dbg_soft_csr #(
      .DBG_USER_ID (DBG_USER_ID)
    ) u_csr (
      .reconfig_clk     (reconfig_clk),
      .reset            (reset),
      .bus_req          (split_req[ch]),
      .bus_rsp          (split_rsp[ch]),
      .phy_req          (phy_req[ch]),
      .phy_rsp          (phy_rsp[ch]),
      .phy_status       (phy_status[ch]),
      .ctrl_in          (ctrl_in[ch]),
      .ctrl_out         (ctrl_out[ch]),
      .tx_cal_busy_mask (tx_cal_busy_mask[ch]),
      .rx_cal_busy_mask (rx_cal_busy_mask[ch]),
      .prbs_ctrl        (prbs_ctrl),
      .prbs_done        (prbs_done),
      .err_snap         (err_snap),
      .bit_snap         (bit_snap)
    );

    prbs_accum u_prbs (
      .reconfig_clk     (reconfig_clk),
      .reset            (reset),
      .prbs_ctrl        (prbs_ctrl),
      .rx_prbs_err_clr  (rx_prbs_err_clr[ch]),
      .prbs_err_signal  (prbs_err_signal[ch]),
      .prbs_done_signal (prbs_done_signal[ch]),
      .prbs_err_clr     (prbs_err_clr[ch]),
      .prbs_done        (prbs_done),
      .err_snap         (err_snap),
      .bit_snap         (bit_snap)
    );
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
// Reconfiguration clock and synchronous reset for the testbench; reset is
// held high for a set number of rising edges after start
module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk = ~clk;
    end
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== verification/xcvr_rcfg_tb.sv ====
// Directed testbench for the reconfiguration front end that drives host accesses
// to the PHY models and debug CSRs of every channel, overrides and PRBS counting
module xcvr_rcfg_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import xcvr_bus_pkg::*;
  import xcvr_dbg_pkg::*;

  localparam int CHANNELS    = 4;
  localparam int CLK_PERIOD  = 8;
  localparam int PHY_OPS     = 6;
  localparam int PRBS_CYCLES = 24;
  // A CSR write completes 2 edges after its strobe rises
  localparam int CSR_CYCLES  = 2;
  // Host accesses made by the tests in the order they run
  localparam int NUM_ACCESSES = CHANNELS + 2 * CHANNELS * PHY_OPS + CHANNELS + 4 + 34 +
                                (16 - CHANNELS);

  logic                clk;
  logic                reset;
  host_req_t           host_req;
  host_rsp_t           host_rsp;
  chan_req_t           phy_req [CHANNELS];
  chan_rsp_t           phy_rsp [CHANNELS];
  phy_status_t         phy_status [CHANNELS];
  phy_ctrl_t           ctrl_in [CHANNELS];
  phy_ctrl_t           ctrl_out [CHANNELS];
  logic [CHANNELS-1:0] tx_mask;
  logic [CHANNELS-1:0] rx_mask;
  logic [CHANNELS-1:0] prbs_err_signal;
  logic [CHANNELS-1:0] prbs_done_signal;
  logic [CHANNELS-1:0] rx_prbs_err_clr;
  logic [CHANNELS-1:0] prbs_err_clr;
  logic [7:0]          phy_mem [CHANNELS][1024];
  logic [7:0]          exp_mem [CHANNELS][1024];
  int                  phy_cnt [CHANNELS];
  int                  seed = 37693;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk (.clk(clk), .reset(reset));

  xcvr_rcfg_top #(
    .CHANNELS    (CHANNELS),
    .DBG_USER_ID (8'h5A)
  ) DUT (
    .reconfig_clk     (clk),
    .reset            (reset),
    .host_req         (host_req),
    .host_rsp         (host_rsp),
    .phy_req          (phy_req),
    .phy_rsp          (phy_rsp),
    .phy_status       (phy_status),
    .ctrl_in          (ctrl_in),
    .ctrl_out         (ctrl_out),
    .tx_cal_busy_mask (tx_mask),
    .rx_cal_busy_mask (rx_mask),
    .prbs_err_signal  (prbs_err_signal),
    .prbs_done_signal (prbs_done_signal),
    .rx_prbs_err_clr  (rx_prbs_err_clr),
    .prbs_err_clr     (prbs_err_clr)
  );

  function automatic int phy_latency(input int ch);
    return ch % 3 + 1;
  endfunction

  // PHY models hold waitrequest high for a per-channel number of cycles
  always @(posedge clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (reset || !(phy_req[ch].read || phy_req[ch].write)) begin
        phy_cnt[ch] <= 0;
      end else if (phy_cnt[ch] == phy_latency(ch)) begin
        phy_cnt[ch] <= 0;
        if (phy_req[ch].write) begin
          phy_mem[ch][phy_req[ch].address] <= phy_req[ch].writedata;
        end
      end else begin
        phy_cnt[ch] <= phy_cnt[ch] + 1;
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      phy_rsp[ch].readdata    = phy_mem[ch][phy_req[ch].address];
      phy_rsp[ch].waitrequest = (phy_req[ch].read || phy_req[ch].write) &&
                                (phy_cnt[ch] != phy_latency(ch));
    end
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
      $display(">>> FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Sampled mid-cycle; the access completes on the following rising edge
  task automatic host_access(input logic is_write, input logic [3:0] sel,
                             input logic [9:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    host_req.write     = is_write;
    host_req.read      = ~is_write;
    host_req.address   = {sel, addr};
    host_req.writedata = wdata;
    @(negedge clk);
    while (host_rsp.waitrequest) begin
      @(negedge clk);
    end
    rdata = host_rsp.readdata;
    next_cycle();
    host_req.write = 1'b0;
    host_req.read  = 1'b0;
  endtask

  task automatic host_write(input logic [3:0] sel, input logic [9:0] addr,
                            input logic [31:0] wdata);
    logic [31:0] unused;
    host_access(1'b1, sel, addr, wdata, unused);
  endtask

  task automatic host_read(input logic [3:0] sel, input logic [9:0] addr,
                           output logic [31:0] rdata);
    host_access(1'b0, sel, addr, 32'h0, rdata);
  endtask

  task automatic read_prbs_snapshot(input int ch, output logic [63:0] err_cnt,
                                    output logic [63:0] bit_cnt);
    logic [31:0] rd;
    err_cnt = '0;
    bit_cnt = '0;
    for (int i = 0; i < PRBS_BYTES; i++) begin
      host_read(ch, {1'b1, 9'(REG_PRBS_ERR0 + i)}, rd);
      err_cnt[8*i +: 8] = rd[7:0];
      host_read(ch, {1'b1, 9'(REG_PRBS_BIT0 + i)}, rd);
      bit_cnt[8*i +: 8] = rd[7:0];
    end
  endtask

  task automatic fill_phy_memories();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int a = 0; a < 1024; a++) begin
        phy_mem[ch][a] = 8'(a * 7 + (a >> 8) + ch * 61);
        exp_mem[ch][a] = 8'(a * 7 + (a >> 8) + ch * 61);
      end
    end
  endtask

  task automatic reset_defaults();
    logic [31:0] rd;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      check_equal(phy_req[ch].read | phy_req[ch].write, 0, "PHY strobe after reset");
      check_equal(ctrl_out[ch], ctrl_in[ch], $sformatf("ch%0d ctrl_out after reset", ch));
      check_equal({tx_mask[ch], rx_mask[ch]}, 2'b11, $sformatf("ch%0d cal masks", ch));
      host_read(ch, {1'b1, REG_ID}, rd);
      check_equal(rd, 32'h5A, $sformatf("ch%0d REG_ID", ch));
    end
  endtask

  task automatic phy_data_path();
    logic [9:0]  addrs [PHY_OPS];
    logic [31:0] wdata;
    logic [31:0] rd;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int i = 0; i < PHY_OPS; i++) begin
        addrs[i] = 10'($random(seed)) & 10'h1FF;
        wdata    = $random(seed);
        host_write(ch, addrs[i], wdata);
        exp_mem[ch][addrs[i]] = wdata[7:0];
      end
      for (int i = 0; i < PHY_OPS; i++) begin
        host_read(ch, addrs[i], rd);
        check_equal(rd, {24'h0, exp_mem[ch][addrs[i]]}, $sformatf("ch%0d PHY read", ch));
      end
    end
    // Compare whole memories so that a stray write on any channel shows up
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int a = 0; a < 1024; a++) begin
        check_equal(phy_mem[ch][a], exp_mem[ch][a], $sformatf("ch%0d PHY byte %0d", ch, a));
      end
    end
  endtask

  task automatic status_readback();
    logic [31:0] rd;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      phy_status[ch] = 5'($random(seed));
      host_read(ch, {1'b1, REG_STATUS}, rd);
      check_equal(rd, {27'h0, phy_status[ch]}, $sformatf("ch%0d REG_STATUS", ch));
    end
  endtask

  task automatic override_and_masks();
    int                           target;
    logic [$bits(phy_ctrl_t)-1:0] en;
    logic [$bits(phy_ctrl_t)-1:0] val;
    logic [$bits(phy_ctrl_t)-1:0] in_bits;
    logic [$bits(phy_ctrl_t)-1:0] expected;
    target = 2;
    en     = 7'($random(seed));
    val    = 7'($random(seed));
    host_write(target, {1'b1, REG_OVR_EN}, en);
    host_write(target, {1'b1, REG_OVR_VAL}, val);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      ctrl_in[ch] = 7'($random(seed));
    end
    next_cycle();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      in_bits = ctrl_in[ch];
      // Enabled bits take the override value on the written channel only
      for (int b = 0; b < $bits(phy_ctrl_t); b++) begin
        if (ch == target && en[b]) begin
          expected[b] = val[b];
        end else begin
          expected[b] = in_bits[b];
        end
      end
      check_equal(ctrl_out[ch], expected, $sformatf("ch%0d ctrl_out override", ch));
    end
    host_write(target, {1'b1, REG_CAL_MASK}, 32'h0);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      check_equal(tx_mask[ch], ch != target, $sformatf("ch%0d tx mask", ch));
      check_equal(rx_mask[ch], ch != target, $sformatf("ch%0d rx mask", ch));
    end
    // Bit 0 is the tx mask, bit 1 the rx mask
    host_write(target, {1'b1, REG_CAL_MASK}, 32'h1);
    check_equal({rx_mask[target], tx_mask[target]}, 2'b01, "cal mask bit order");
  endtask

  task automatic prbs_count_snapshot();
    int          target;
    int          errors;
    logic        err_bit;
    logic [31:0] rd;
    logic [63:0] err_cnt;
    logic [63:0] bit_cnt;
    target = 1;
    errors = 0;
    prbs_done_signal[target] = 1'b1;
    host_write(target, {1'b1, REG_PRBS_CTRL}, 32'h1);
    for (int i = 0; i < PRBS_CYCLES; i++) begin
      err_bit = 1'($random(seed));
      prbs_err_signal[target] = err_bit;
      errors += err_bit;
      next_cycle();
    end
    prbs_err_signal[target] = 1'b0;
    // Counting runs on until the disable write completes
    host_write(target, {1'b1, REG_PRBS_CTRL}, 32'h0);
    host_write(target, {1'b1, REG_PRBS_CTRL}, 32'h2);
    read_prbs_snapshot(target, err_cnt, bit_cnt);
    check_equal(err_cnt, errors, "PRBS error count");
    check_equal(bit_cnt, PRBS_CYCLES + CSR_CYCLES, "PRBS bit count");
    host_read(target, {1'b1, REG_PRBS_CTRL}, rd);
    check_equal(rd, 32'h8, "PRBS done readback");
    host_write(target, {1'b1, REG_PRBS_CTRL}, 32'h4);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      check_equal(prbs_err_clr[ch], ch == target, $sformatf("ch%0d prbs_err_clr", ch));
    end
    next_cycle();
    check_equal(prbs_err_clr[target], 1'b0, "prbs_err_clr is one cycle");
    host_write(target, {1'b1, REG_PRBS_CTRL}, 32'h2);
    read_prbs_snapshot(target, err_cnt, bit_cnt);
    check_equal(err_cnt, 0, "PRBS error count after clear");
    check_equal(bit_cnt, 0, "PRBS bit count after clear");
  endtask

  task automatic out_of_range_select();
    logic [31:0] rd;
    for (int sel = CHANNELS; sel < 16; sel++) begin
      host_read(sel, 10'($random(seed)), rd);
      check_equal(rd, 32'h0, $sformatf("select %0d readdata", sel));
    end
  endtask

  initial begin
    host_req         = '0;
    prbs_err_signal  = '0;
    prbs_done_signal = '0;
    rx_prbs_err_clr  = '0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      phy_status[ch] = '0;
      ctrl_in[ch]    = 7'($random(seed));
    end
    fill_phy_memories();
    wait (reset === 1'b0);
    next_cycle();
    reset_defaults();
    phy_data_path();
    status_readback();
    override_and_masks();
    prbs_count_snapshot();
    out_of_range_select();
    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(NUM_ACCESSES * 200 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d ns",
             NUM_ACCESSES * 200 * CLK_PERIOD);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== flist.f ====
logic/xcvr_bus_pkg.sv
logic/xcvr_dbg_pkg.sv
logic/rcfg_channel_split.sv
logic/dbg_soft_csr.sv
logic/prbs_accum.sv
logic/xcvr_rcfg_top.sv
verification/tb_clock_gen.sv
verification/xcvr_rcfg_tb.sv

// ==== Bender.yml ====
package:
  name: xcvr_rcfg

sources:
  - files:
      - logic/xcvr_bus_pkg.sv
      - logic/xcvr_dbg_pkg.sv
      - logic/rcfg_channel_split.sv
      - logic/dbg_soft_csr.sv
      - logic/prbs_accum.sv
      - logic/xcvr_rcfg_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/xcvr_rcfg_tb.sv
